// File: list.f
nnPkg.sv
neuronNode.sv
layerEngine.sv
actArbiter.sv
actMem.sv
apbHost.sv
nnLayerTop.sv
nnLayerAssertions.sv
nnLayerTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module nnLayerTb \
	-f list.f -o nnLayerSim

# The exit status of tee is kept, so the log search decides the result.
./obj_dir/nnLayerSim +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
	exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1

// File: nnLayerTb.sv
`timescale 1ns/1ps

module nnLayerTb;
	import nnPkg::*;

	localparam int numPasses = 16;
	localparam int watchPasses = 20;
	localparam int cyclesPerPass = 200;

	// Same weights as the top level with input 9 first.
	localparam weightVec modelW [numNodes] = '{
		{8'sd32, 8'sd62, -8'sd8, -8'sd38, 8'sd54, -8'sd6, 8'sd38, 8'sd36, -8'sd42, 8'sd12},
		{-8'sd5, 8'sd9, 8'sd18, -8'sd12, 8'sd40, 8'sd25, -8'sd33, 8'sd7, 8'sd15, -8'sd20},
		{8'sd7, 8'sd3, -8'sd2, 8'sd1, 8'sd4, -8'sd6, 8'sd2, 8'sd8, -8'sd3, 8'sd5},
		{8'sd14, 8'sd22, -8'sd8, 8'sd50, -8'sd29, 8'sd11, 8'sd45, -8'sd17, 8'sd31, -8'sd64}
	};
	localparam int modelB [numNodes] = '{-512, 256, 12000, -1024};

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [apbAddrWidth-1:0] paddr;
	logic [apbDataWidth-1:0] pwdata;
	logic [apbDataWidth-1:0] prdata;
	logic pready;
	logic pslverr;

	logic lastErr;
	logic [7:0] expDone;
	logic [31:0] seed;
	int errors;

	nnLayerTop nnLayerTop_i (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	bind nnLayerTop nnLayerAssertions checks (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pready(pready),
		.startPulse(startPulse),
		.busy(busy),
		.hostReq(hostReq),
		.engReq(engReq),
		.hostGrant(hostGrant),
		.engGrant(engGrant)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Bias plus signed products, ReLU, divide by 64 rounding half up, clip at 127.
	function automatic logic [7:0] neuronModel(input weightVec w, input int b, input actVec a);
		int sum;
		int q;
		sum = b;
		for (int i = 0; i < numInputs; i++)
			sum = sum + int'($signed(a[i])) * int'($signed(w[i]));
		if (sum < 0)
			return 8'd0;
		q = (sum + 32) / 64;
		if (q > 127)
			q = 127;
		return 8'(q);
	endfunction

	task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp)
		else
		begin
			errors++;
			$display("FAIL %0t: %s, got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic apbWrite(input logic [apbAddrWidth-1:0] addr, input logic [31:0] data);
		@(posedge clk);
		psel <= 1'b1;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		while (!pready)
			@(posedge clk);
		lastErr = pslverr;
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apbRead(input logic [apbAddrWidth-1:0] addr, output logic [31:0] data);
		@(posedge clk);
		psel <= 1'b1;
		pwrite <= 1'b0;
		paddr <= addr;
		pwdata <= '0;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		while (!pready)
			@(posedge clk);
		data = prdata;
		lastErr = pslverr;
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic waitIdle(output logic [31:0] status);
		apbRead(statusAddr, status);
		while (status[0])
			apbRead(statusAddr, status);
	endtask

	task automatic runPass(input actVec vec, input logic readBusy, input logic twoStarts);
		logic [31:0] d;
		logic [31:0] status;
		for (int i = 0; i < numInputs; i++)
			apbWrite(8'(4 * i), {24'd0, vec[i]});
		apbWrite(ctrlAddr, 32'h1);
		// Lands while the engine is still fetching.
		if (twoStarts)
			apbWrite(ctrlAddr, 32'h1);
		if (readBusy)
		begin
			for (int i = 0; i < numInputs; i++)
			begin
				apbRead(8'(4 * i), d);
				checkValue(d, {24'd0, vec[i]}, "input read during a pass");
			end
		end
		waitIdle(status);
		expDone = expDone + 1'b1;
		checkValue(status, {16'd0, expDone, 8'd0}, "status after a pass");
		for (int n = 0; n < numNodes; n++)
		begin
			apbRead(8'(4 * (int'(outBase) + n)), d);
			checkValue(d, {24'd0, neuronModel(modelW[n], modelB[n], vec)},
				$sformatf("node %0d output", n));
		end
	endtask

	initial
	begin
		repeat (watchPasses * cyclesPerPass) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run did not finish",
			watchPasses * cyclesPerPass);
		$display("TESTS FAILED");
		$finish;
	end

	initial
	begin
		actVec vec;
		logic [31:0] d;
		int assertFails;
		errors = 0;
		expDone = '0;
		lastErr = 1'b0;
		seed = 32'h7be3_ae4b;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		apbRead(statusAddr, d);
		checkValue(d, 32'h0, "status after reset");

		// Input and output bytes read back.
		for (int i = 0; i < int'(outBase) + numNodes; i++)
		begin
			if (i < numInputs || i >= int'(outBase))
			begin
				seed = xorshift(seed);
				apbWrite(8'(4 * i), seed);
				apbRead(8'(4 * i), d);
				checkValue(d, {24'd0, seed[7:0]}, $sformatf("read-back of byte %0d", i));
			end
		end

		for (int p = 0; p < numPasses; p++)
		begin
			for (int i = 0; i < numInputs; i++)
			begin
				seed = xorshift(seed);
				vec[i] = seed[7:0];
			end
			if (p == 0)
				vec = {numInputs{8'h80}};
			else if (p == 1)
				vec = {numInputs{8'h7f}};
			runPass(vec, p == 2, p == 3);
		end

		// Out of range access.
		apbWrite(8'h88, 32'hffff_ffff);
		checkValue(32'(lastErr), 32'd1, "pslverr on write beyond status");
		apbRead(8'h88, d);
		checkValue(32'(lastErr), 32'd1, "pslverr on read beyond status");
		apbRead(statusAddr, d);
		checkValue(d, {16'd0, expDone, 8'd0}, "status after bad access");
		// Byte 2 is where 0x88 lands if the upper address bits are ignored.
		apbRead(8'h08, d);
		checkValue(d, {24'd0, vec[2]}, "memory after bad access");

		assertFails = nnLayerTop_i.checks.failCount;
		$display("Error count: %0d value checks, %0d assertion failures", errors, assertFails);
		if (errors == 0 && assertFails == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: nnLayerAssertions.sv
`timescale 1ns/1ps

module nnLayerAssertions (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic startPulse,
	input logic busy,
	input nnPkg::memReq hostReq,
	input nnPkg::memReq engReq,
	input logic hostGrant,
	input logic engGrant
);
	int failCount = 0;

	// A memory access ends in the access phase one cycle after its grant.
	readyAfterGrant: assert property (@(posedge clk) disable iff (reset)
		hostGrant |=> pready && psel && penable)
	else
	begin
		$error("the APB access did not complete one cycle after its memory grant");
		failCount++;
	end

	// On a conflict the last owner loses.
	engineYields: assert property (@(posedge clk) disable iff (reset)
		engGrant ##1 (hostReq.valid && engReq.valid) |-> hostGrant && !engGrant)
	else
	begin
		$error("the engine kept the memory on a conflict right after its own grant");
		failCount++;
	end

	// A waiting request may not change.
	hostHeld: assert property (@(posedge clk) disable iff (reset)
		hostReq.valid && !hostGrant |=> $stable(hostReq))
	else
	begin
		$error("host request changed before it was granted");
		failCount++;
	end

	engHeld: assert property (@(posedge clk) disable iff (reset)
		engReq.valid && !engGrant |=> $stable(engReq))
	else
	begin
		$error("engine request changed before it was granted");
		failCount++;
	end

	startToBusy: assert property (@(posedge clk) disable iff (reset)
		startPulse && !busy |=> busy)
	else
	begin
		$error("busy did not rise one cycle after a start pulse");
		failCount++;
	end

endmodule

// File: nnLayerTop.sv
`timescale 1ns/1ps

// Weight vectors are listed from input 9 down to input 0.
module nnLayerTop #(
	parameter nnPkg::weightVec weights0 = {
		8'sd32, 8'sd62, -8'sd8, -8'sd38, 8'sd54, -8'sd6, 8'sd38, 8'sd36, -8'sd42, 8'sd12},
	parameter nnPkg::weightVec weights1 = {
		-8'sd5, 8'sd9, 8'sd18, -8'sd12, 8'sd40, 8'sd25, -8'sd33, 8'sd7, 8'sd15, -8'sd20},
	parameter nnPkg::weightVec weights2 = {
		8'sd7, 8'sd3, -8'sd2, 8'sd1, 8'sd4, -8'sd6, 8'sd2, 8'sd8, -8'sd3, 8'sd5},
	parameter nnPkg::weightVec weights3 = {
		8'sd14, 8'sd22, -8'sd8, 8'sd50, -8'sd29, 8'sd11, 8'sd45, -8'sd17, 8'sd31, -8'sd64},
	parameter logic signed [nnPkg::biasWidth-1:0] bias0 = -16'sd512,
	parameter logic signed [nnPkg::biasWidth-1:0] bias1 = 16'sd256,
	// Large enough to drive most inputs into saturation.
	parameter logic signed [nnPkg::biasWidth-1:0] bias2 = 16'sd12000,
	parameter logic signed [nnPkg::biasWidth-1:0] bias3 = -16'sd1024
) (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [nnPkg::apbAddrWidth-1:0] paddr,
	input logic [nnPkg::apbDataWidth-1:0] pwdata,
	output logic [nnPkg::apbDataWidth-1:0] prdata,
	output logic pready,
	output logic pslverr
);
	import nnPkg::*;

	memReq hostReq;
	memReq engReq;
	memReq memSel;
	logic hostGrant;
	logic engGrant;
	logic startPulse;
	logic busy;
	logic [actWidth-1:0] memRdata;

	apbHost apbHost_i (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.busy(busy),
		.startPulse(startPulse),
		.req(hostReq),
		.grant(hostGrant),
		.rdata(memRdata)
	);

	layerEngine #(
		.weights0(weights0),
		.weights1(weights1),
		.weights2(weights2),
		.weights3(weights3),
		.bias0(bias0),
		.bias1(bias1),
		.bias2(bias2),
		.bias3(bias3)
	) layerEngine_i (
		.clk(clk),
		.reset(reset),
		.startPulse(startPulse),
		.req(engReq),
		.grant(engGrant),
		.rdata(memRdata),
		.busy(busy)
	);

	actArbiter actArbiter_i (
		.clk(clk),
		.reset(reset),
		.hostReq(hostReq),
		.engReq(engReq),
		.hostGrant(hostGrant),
		.engGrant(engGrant),
		.memSel(memSel)
	);

	actMem actMem_i (
		.clk(clk),
		.req(memSel),
		.rdata(memRdata)
	);

endmodule

// File: apbHost.sv
`timescale 1ns/1ps

module apbHost (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [nnPkg::apbAddrWidth-1:0] paddr,
	input logic [nnPkg::apbDataWidth-1:0] pwdata,
	output logic [nnPkg::apbDataWidth-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic busy,
	output logic startPulse,
	output nnPkg::memReq req,
	input logic grant,
	input logic [nnPkg::actWidth-1:0] rdata
);
	import nnPkg::*;

	logic access;
	logic isMem;
	logic isCtrl;
	logic isStatus;
	logic isErr;
	logic granted;
	logic busyPrev;
	logic [7:0] doneCount;
	logic [apbDataWidth-1:0] statusWord;

	assign access = psel && penable;
	assign isMem = paddr < ctrlAddr;
	assign isCtrl = paddr[apbAddrWidth-1:2] == ctrlAddr[apbAddrWidth-1:2];
	assign isStatus = paddr == statusAddr;
	assign isErr = paddr > statusAddr;

	// Request is dropped as soon as the grant is seen.
	always_comb
	begin
		req = '0;
		req.valid = access && isMem && !granted;
		req.write = pwrite;
		req.addr = paddr[addrWidth+1:2];
		req.wdata = pwdata[actWidth-1:0];
	end

	// Memory accesses end the cycle after their grant.
	assign pready = access && (isMem ? granted : 1'b1);
	assign pslverr = access && isErr;

	// Busy is held one extra cycle so the count is settled when it reads 0.
	always_comb
	begin
		statusWord = '0;
		statusWord[15:8] = doneCount;
		statusWord[0] = busy || busyPrev;
	end

	always_comb
	begin
		prdata = '0;
		if (isMem)
			prdata[actWidth-1:0] = rdata;
		else if (isStatus)
			prdata = statusWord;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			granted <= 1'b0;
			startPulse <= 1'b0;
			busyPrev <= 1'b0;
			doneCount <= '0;
		end
		else
		begin
			if (pready)
				granted <= 1'b0;
			else if (grant)
				granted <= 1'b1;
			startPulse <= access && pwrite && isCtrl && pwdata[0];
			busyPrev <= busy;
			// One count per falling edge of busy.
			if (busyPrev && !busy)
				doneCount <= doneCount + 1'b1;
		end
	end

endmodule

// File: actMem.sv
`timescale 1ns/1ps

module actMem (
	input logic clk,
	input nnPkg::memReq req,
	output logic [nnPkg::actWidth-1:0] rdata
);
	import nnPkg::*;

	logic [actWidth-1:0] mem [memDepth];

	always_ff @(posedge clk)
	begin
		if (req.valid && req.write)
			mem[req.addr] <= req.wdata;
	end

	// Holds the last read byte until the next read.
	always_ff @(posedge clk)
	begin
		if (req.valid && !req.write)
			rdata <= mem[req.addr];
	end

endmodule

// File: actArbiter.sv
`timescale 1ns/1ps

module actArbiter (
	input logic clk,
	input logic reset,
	input nnPkg::memReq hostReq,
	input nnPkg::memReq engReq,
	output logic hostGrant,
	output logic engGrant,
	output nnPkg::memReq memSel
);
	import nnPkg::*;

	owner lastOwner;

	always_comb
	begin
		hostGrant = hostReq.valid;
		engGrant = engReq.valid;
		// On a conflict the last owner yields.
		if (hostReq.valid && engReq.valid)
		begin
			hostGrant = lastOwner == ownEngine;
			engGrant = lastOwner == ownHost;
		end
	end

	always_comb
	begin
		memSel = '0;
		if (hostGrant)
			memSel = hostReq;
		else if (engGrant)
			memSel = engReq;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			lastOwner <= ownHost;
		else if (hostGrant)
			lastOwner <= ownHost;
		else if (engGrant)
			lastOwner <= ownEngine;
	end

endmodule

// File: layerEngine.sv
`timescale 1ns/1ps

module layerEngine #(
	parameter nnPkg::weightVec weights0 = '0,
	parameter nnPkg::weightVec weights1 = '0,
	parameter nnPkg::weightVec weights2 = '0,
	parameter nnPkg::weightVec weights3 = '0,
	parameter logic signed [nnPkg::biasWidth-1:0] bias0 = '0,
	parameter logic signed [nnPkg::biasWidth-1:0] bias1 = '0,
	parameter logic signed [nnPkg::biasWidth-1:0] bias2 = '0,
	parameter logic signed [nnPkg::biasWidth-1:0] bias3 = '0
) (
	input logic clk,
	input logic reset,
	input logic startPulse,
	output nnPkg::memReq req,
	input logic grant,
	input logic [nnPkg::actWidth-1:0] rdata,
	output logic busy
);
	import nnPkg::*;

	localparam weightVec [numNodes-1:0] weightSet = {weights3, weights2, weights1, weights0};
	localparam logic [numNodes-1:0][biasWidth-1:0] biasSet = {bias3, bias2, bias1, bias0};
	localparam int countWidth = $clog2(numInputs + 1);
	localparam int nodeIdxWidth = $clog2(numNodes);
	localparam int nodeLatency = 3;

	engineState state;
	logic [countWidth-1:0] count;
	logic [countWidth-1:0] capIdx;
	logic capValid;
	actVec actBus;
	logic [numNodes-1:0][actWidth-1:0] nodeOut;

	assign busy = state != idle;

	always_comb
	begin
		req = '0;
		case (state)
			fetch:
			begin
				req.valid = count < numInputs;
				req.addr = inBase + addrWidth'(count);
			end
			store:
			begin
				req.valid = 1'b1;
				req.write = 1'b1;
				req.addr = outBase + addrWidth'(count);
				req.wdata = nodeOut[count[nodeIdxWidth-1:0]];
			end
			default:
				req.valid = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idle;
			count <= '0;
			capValid <= 1'b0;
		end
		else
		begin
			capValid <= state == fetch && grant;
			case (state)
				idle:
					if (startPulse)
					begin
						state <= fetch;
						count <= '0;
					end
				fetch:
					// Leave once the last byte lands on the bus.
					if (capValid && capIdx == countWidth'(numInputs - 1))
					begin
						state <= compute;
						count <= '0;
					end
					else if (grant)
						count <= count + 1'b1;
				compute:
					if (count == countWidth'(nodeLatency - 1))
					begin
						state <= store;
						count <= '0;
					end
					else
						count <= count + 1'b1;
				store:
					if (grant)
					begin
						if (count == countWidth'(numNodes - 1))
							state <= idle;
						count <= count + 1'b1;
					end
			endcase
		end
	end

	// Read data returns one cycle after the grant.
	always_ff @(posedge clk)
	begin
		if (state == fetch && grant)
			capIdx <= count;
		if (capValid)
			actBus[capIdx] <= rdata;
	end

	for (genvar g = 0; g < numNodes; g++)
	begin : nodeGen
		neuronNode #(
			.weights(weightSet[g]),
			.bias(biasSet[g])
		) neuronNode_i (
			.clk(clk),
			.reset(reset),
			.actIn(actBus),
			.nodeOut(nodeOut[g])
		);
	end

endmodule

// File: neuronNode.sv
`timescale 1ns/1ps

module neuronNode #(
	parameter nnPkg::weightVec weights = '0,
	parameter logic signed [nnPkg::biasWidth-1:0] bias = '0
) (
	input logic clk,
	input logic reset,
	input nnPkg::actVec actIn,
	output logic [nnPkg::actWidth-1:0] nodeOut
);
	import nnPkg::*;

	localparam logic [accWidth-1:0] half = 1 << (fracBits - 1);

	actVec actReg;
	logic signed [accWidth-1:0] sum;
	logic signed [accWidth-1:0] accReg;
	logic [accWidth-1:0] rounded;

	// Products are formed at full accumulator width.
	always_comb
	begin
		sum = bias;
		for (int i = 0; i < numInputs; i++)
			sum = sum + $signed(actReg[i]) * $signed(weights[i]);
	end

	// Only meaningful for a non-negative sum.
	assign rounded = ($unsigned(accReg) + half) >> fracBits;

	always_ff @(posedge clk)
	begin
		actReg <= actIn;
		accReg <= sum;
	end

	// ReLU, then saturate.
	always_ff @(posedge clk)
	begin
		if (reset)
			nodeOut <= '0;
		else if (accReg[accWidth-1])
			nodeOut <= '0;
		else if (rounded > satMax)
			nodeOut <= actWidth'(satMax);
		else
			nodeOut <= rounded[actWidth-1:0];
	end

endmodule

// File: nnPkg.sv
package nnPkg;

	localparam int actWidth = 8;
	localparam int biasWidth = 16;
	localparam int accWidth = 23;
	localparam int numInputs = 10;
	localparam int numNodes = 4;
	localparam int memDepth = 32;
	localparam int addrWidth = $clog2(memDepth);
	localparam int apbAddrWidth = 8;
	localparam int apbDataWidth = 32;

	// Byte indices in the activation memory.
	localparam logic [addrWidth-1:0] inBase = 5'd0;
	localparam logic [addrWidth-1:0] outBase = 5'd16;

	// Memory bytes sit below ctrlAddr at four times their index.
	localparam logic [apbAddrWidth-1:0] ctrlAddr = 8'h80;
	localparam logic [apbAddrWidth-1:0] statusAddr = 8'h84;

	// Neuron rule.
	// The sum is the bias plus each activation times its weight, all signed.
	// A negative sum gives 0.
	// Otherwise the sum is divided by 64, rounded half up and limited to 127.
	localparam int fracBits = 6;
	localparam int satMax = 127;

	typedef logic signed [actWidth-1:0] sByte;
	typedef sByte [numInputs-1:0] weightVec;
	typedef sByte [numInputs-1:0] actVec;

	typedef struct packed {
		logic valid;
		logic write;
		logic [addrWidth-1:0] addr;
		logic [actWidth-1:0] wdata;
	} memReq;

	typedef enum logic {
		ownHost,
		ownEngine
	} owner;

	typedef enum logic [1:0] {
		idle,
		fetch,
		compute,
		store
	} engineState;

endpackage
